// ==== source/uart_pkg.sv ====
/* UART shared types */
package uart_pkg;

	// One data byte on the line or in a FIFO.
	typedef logic [7:0] uart_byte_t;

	// Data bits sent or received so far, 0 to 8.
	typedef logic [3:0] bit_index_t;

	// Transmitter sequencing.
	typedef enum logic [2:0] {
		tx_idle,
		tx_fetch,
		tx_load,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_t;

	// Receiver sequencing.
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

endpackage

// ==== source/fifo_if.sv ====
/* FIFO port bundle */
interface fifo_if;

	logic write;
	uart_pkg::uart_byte_t wdata;
	logic full;
	logic read;
	uart_pkg::uart_byte_t rdata;
	logic empty;

	// Queue side.
	modport store (
		input write,
		input wdata,
		input read,
		output full,
		output rdata,
		output empty
	);

	// Transmitter or receiver side.
	modport user (
		output write,
		output wdata,
		output read,
		input full,
		input rdata,
		input empty
	);

endinterface

// ==== source/sync_fifo.sv ====
/* Synchronous byte FIFO */
module sync_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input logic i_clock,
	input logic i_reset,
	fifo_if.store q
);

	localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
	localparam logic [ADDR_WIDTH:0] PTR_STEP = {{ADDR_WIDTH{1'b0}}, 1'b1};

	uart_pkg::uart_byte_t mem [FIFO_DEPTH];

	// Extra top bit tells a full queue from an empty one.
	logic [ADDR_WIDTH:0] wr_ptr;
	logic [ADDR_WIDTH:0] rd_ptr;
	logic [ADDR_WIDTH-1:0] wr_addr;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic do_write;
	logic do_read;

	assign wr_addr = wr_ptr[ADDR_WIDTH-1:0];
	assign rd_addr = rd_ptr[ADDR_WIDTH-1:0];

	assign q.empty = (wr_ptr == rd_ptr);
	assign q.full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) && (wr_addr == rd_addr);

	// Writes when full and reads when empty are dropped.
	assign do_write = q.write && !q.full;
	assign do_read = q.read && !q.empty;

	// Head entry is visible without a read.
	assign q.rdata = mem[rd_addr];

	always_ff @(posedge i_clock) begin
		if (do_write)
			mem[wr_addr] <= q.wdata;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + PTR_STEP;
			if (do_read)
				rd_ptr <= rd_ptr + PTR_STEP;
		end
	end

endmodule

// ==== source/uart_tx.sv ====
/* UART transmitter */
module uart_tx #(
	parameter int CLOCKS_PER_BIT = 16
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input uart_pkg::uart_byte_t i_data,
	output logic o_ready,
	output logic o_serial,
	fifo_if.user q
);

	localparam int BAUD_WIDTH = $clog2(CLOCKS_PER_BIT);
	localparam logic [BAUD_WIDTH-1:0] BAUD_LAST = BAUD_WIDTH'(CLOCKS_PER_BIT - 1);
	localparam logic [BAUD_WIDTH-1:0] BAUD_STEP = BAUD_WIDTH'(1);

	uart_pkg::tx_state_t state;
	logic [BAUD_WIDTH-1:0] baud;
	uart_pkg::bit_index_t bit_count;
	uart_pkg::uart_byte_t shift;
	logic fetch_read;
	logic accept;
	logic on_line;
	logic bit_done;

	// One byte per ready pulse.
	assign accept = i_request && !q.full && !o_ready;
	assign q.write = accept;
	assign q.wdata = i_data;
	assign q.read = fetch_read;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_ready <= 1'b0;
		else
			o_ready <= accept;
	end

	assign on_line = (state == uart_pkg::tx_start) || (state == uart_pkg::tx_data) ||
		(state == uart_pkg::tx_stop);
	assign bit_done = on_line && (baud == BAUD_LAST);

	// Bit timer.
	always_ff @(posedge i_clock) begin
		if (i_reset || !on_line || bit_done)
			baud <= '0;
		else
			baud <= baud + BAUD_STEP;
	end

	// Shifts out LSB first.
	always_ff @(posedge i_clock) begin
		if (state == uart_pkg::tx_load)
			shift <= q.rdata;
		else if (bit_done && state != uart_pkg::tx_stop)
			shift <= {1'b0, shift[7:1]};
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= uart_pkg::tx_idle;
			bit_count <= '0;
			fetch_read <= 1'b0;
			o_serial <= 1'b1;
		end else begin
			case (state)
				uart_pkg::tx_idle: begin
					if (!q.empty)
						state <= uart_pkg::tx_fetch;
				end
				uart_pkg::tx_fetch: begin
					fetch_read <= 1'b1;
					state <= uart_pkg::tx_load;
				end
				uart_pkg::tx_load: begin
					// Head is popped on the same edge it is latched.
					fetch_read <= 1'b0;
					bit_count <= '0;
					o_serial <= 1'b0;
					state <= uart_pkg::tx_start;
				end
				uart_pkg::tx_start: begin
					if (bit_done) begin
						o_serial <= shift[0];
						bit_count <= 4'd1;
						state <= uart_pkg::tx_data;
					end
				end
				uart_pkg::tx_data: begin
					if (bit_done) begin
						if (bit_count == 4'd8) begin
							o_serial <= 1'b1;
							state <= uart_pkg::tx_stop;
						end else begin
							o_serial <= shift[0];
							bit_count <= bit_count + 4'd1;
						end
					end
				end
				uart_pkg::tx_stop: begin
					if (bit_done)
						state <= uart_pkg::tx_idle;
				end
				default: begin
					state <= uart_pkg::tx_idle;
				end
			endcase
		end
	end

endmodule

// ==== source/uart_rx.sv ====
/* UART receiver */
module uart_rx #(
	parameter int CLOCKS_PER_BIT = 16
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_serial,
	output logic o_frame_error,
	output logic o_overrun,
	fifo_if.user q
);

	localparam int BAUD_WIDTH = $clog2(CLOCKS_PER_BIT);
	localparam logic [BAUD_WIDTH-1:0] BAUD_LAST = BAUD_WIDTH'(CLOCKS_PER_BIT - 1);
	localparam logic [BAUD_WIDTH-1:0] BAUD_HALF = BAUD_WIDTH'(CLOCKS_PER_BIT / 2 - 1);
	localparam logic [BAUD_WIDTH-1:0] BAUD_STEP = BAUD_WIDTH'(1);

	uart_pkg::rx_state_t state;
	logic [BAUD_WIDTH-1:0] baud;
	uart_pkg::bit_index_t bit_count;
	uart_pkg::uart_byte_t shift;
	logic sync_meta;
	logic line;
	logic tick;
	logic write_pulse;

	// Two-flop synchronizer, idle high.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sync_meta <= 1'b1;
			line <= 1'b1;
		end else begin
			sync_meta <= i_serial;
			line <= sync_meta;
		end
	end

	// Half a bit to the start centre, then whole bits.
	assign tick = (state == uart_pkg::rx_start) ? (baud == BAUD_HALF) :
		(state != uart_pkg::rx_idle) && (baud == BAUD_LAST);

	always_ff @(posedge i_clock) begin
		if (i_reset || state == uart_pkg::rx_idle || tick)
			baud <= '0;
		else
			baud <= baud + BAUD_STEP;
	end

	// Data arrives LSB first.
	always_ff @(posedge i_clock) begin
		if (state == uart_pkg::rx_data && tick)
			shift <= {line, shift[7:1]};
	end

	assign q.write = write_pulse;
	assign q.wdata = shift;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= uart_pkg::rx_idle;
			bit_count <= '0;
			write_pulse <= 1'b0;
			o_frame_error <= 1'b0;
			o_overrun <= 1'b0;
		end else begin
			write_pulse <= 1'b0;
			o_frame_error <= 1'b0;
			o_overrun <= 1'b0;
			case (state)
				uart_pkg::rx_idle: begin
					if (!line)
						state <= uart_pkg::rx_start;
				end
				uart_pkg::rx_start: begin
					bit_count <= '0;
					// A high line at mid start was only a glitch.
					if (tick)
						state <= line ? uart_pkg::rx_idle : uart_pkg::rx_data;
				end
				uart_pkg::rx_data: begin
					if (tick) begin
						bit_count <= bit_count + 4'd1;
						if (bit_count == 4'd7)
							state <= uart_pkg::rx_stop;
					end
				end
				uart_pkg::rx_stop: begin
					if (tick) begin
						state <= uart_pkg::rx_idle;
						if (!line)
							o_frame_error <= 1'b1;
						else if (q.full)
							o_overrun <= 1'b1;
						else
							write_pulse <= 1'b1;
					end
				end
				default: begin
					state <= uart_pkg::rx_idle;
				end
			endcase
		end
	end

endmodule

// ==== source/uart_top.sv ====
/* UART top level */
module uart_top #(
	parameter int CLOCKS_PER_BIT = 16,
	parameter int FIFO_DEPTH = 16
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_tx_request,
	input uart_pkg::uart_byte_t i_tx_data,
	input logic i_rx_serial,
	input logic i_rx_read,
	output logic o_tx_ready,
	output logic o_tx_serial,
	output uart_pkg::uart_byte_t o_rx_data,
	output logic o_rx_valid,
	output logic o_rx_frame_error,
	output logic o_rx_overrun
);

	fifo_if tx_q ();
	fifo_if rx_q ();

	sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.q(tx_q.store)
	);

	sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.q(rx_q.store)
	);

	uart_tx #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) tx (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_tx_request),
		.i_data(i_tx_data),
		.o_ready(o_tx_ready),
		.o_serial(o_tx_serial),
		.q(tx_q.user)
	);

	uart_rx #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) rx (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_serial(i_rx_serial),
		.o_frame_error(o_rx_frame_error),
		.o_overrun(o_rx_overrun),
		.q(rx_q.user)
	);

	// Host drains the receive queue.
	assign rx_q.read = i_rx_read;
	assign o_rx_data = rx_q.rdata;
	assign o_rx_valid = !rx_q.empty;

endmodule

// ==== dv/uart_chk.sv ====
/* UART protocol checks */
module uart_chk (
	input logic i_clock,
	input logic i_reset,
	input logic i_tx_ready,
	input logic i_tx_serial,
	input logic i_rx_valid,
	input logic i_frame_error,
	input logic i_overrun
);
	timeunit 1ns;
	timeprecision 1ns;

	// Ready is a single-cycle strobe.
	ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_tx_ready |=> !i_tx_ready)
		else $error("o_tx_ready high in two consecutive cycles");

	// Line idle and no status right after reset.
	idle_after_reset: assert property (@(posedge i_clock)
		$fell(i_reset) |-> i_tx_serial && !i_tx_ready && !i_rx_valid &&
		!i_frame_error && !i_overrun)
		else $error("Outputs not idle in the cycle after reset");

	no_double_status: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_frame_error && i_overrun))
		else $error("Frame error and overrun pulsed together");

endmodule

bind uart_top uart_chk chk (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_tx_ready(o_tx_ready),
	.i_tx_serial(o_tx_serial),
	.i_rx_valid(o_rx_valid),
	.i_frame_error(o_rx_frame_error),
	.i_overrun(o_rx_overrun)
);

// ==== dv/uart_tb.sv ====
/* UART subsystem testbench */
module uart_tb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLOCKS_PER_BIT = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int LOOP_BYTES = 40;
	localparam int BURST_BYTES = FIFO_DEPTH + 3;
	localparam int OVERRUN_FRAMES = FIFO_DEPTH + 1;
	localparam int TOTAL_FRAMES = LOOP_BYTES + BURST_BYTES + 2 + OVERRUN_FRAMES;
	// Ten bit periods per frame, plus room for gaps and drains.
	localparam int CYCLE_LIMIT = TOTAL_FRAMES * 10 * CLOCKS_PER_BIT + 2000;

	logic i_clock;
	logic i_reset;
	logic i_tx_request;
	uart_pkg::uart_byte_t i_tx_data;
	logic i_rx_serial;
	logic i_rx_read;
	logic o_tx_ready;
	logic o_tx_serial;
	uart_pkg::uart_byte_t o_rx_data;
	logic o_rx_valid;
	logic o_rx_frame_error;
	logic o_rx_overrun;

	logic use_generator;
	logic gen_level;
	logic tx_loop;
	logic read_enable;
	logic [31:0] lfsr_state;
	uart_pkg::uart_byte_t tx_sent [$];
	uart_pkg::uart_byte_t rx_expect [$];
	int mismatch_count = 0;
	int failure_count = 0;
	int frames_seen = 0;
	int bytes_accepted = 0;
	int bytes_read = 0;
	int frame_errors = 0;
	int overruns = 0;
	int full_waits = 0;
	int cycles = 0;

	uart_top #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.FIFO_DEPTH(FIFO_DEPTH)
	) DUT (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_tx_request(i_tx_request),
		.i_tx_data(i_tx_data),
		.i_rx_serial(i_rx_serial),
		.i_rx_read(i_rx_read),
		.o_tx_ready(o_tx_ready),
		.o_tx_serial(o_tx_serial),
		.o_rx_data(o_rx_data),
		.o_rx_valid(o_rx_valid),
		.o_rx_frame_error(o_rx_frame_error),
		.o_rx_overrun(o_rx_overrun)
	);

	always #20 i_clock = ~i_clock;

	// Receive line is either the looped-back transmitter or the frame generator.
	assign i_rx_serial = use_generator ? gen_level : tx_loop;

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		repeat (count) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
			mismatch_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("ERROR: %s", what);
		failure_count++;
	endtask

	task automatic expect_idle();
		compare_value("o_tx_serial", 32'(o_tx_serial), 32'd1);
		compare_value("o_tx_ready", 32'(o_tx_ready), 32'd0);
		compare_value("o_rx_valid", 32'(o_rx_valid), 32'd0);
		compare_value("o_rx_frame_error", 32'(o_rx_frame_error), 32'd0);
		compare_value("o_rx_overrun", 32'(o_rx_overrun), 32'd0);
	endtask

	// Holds the request until ready shows the byte was taken.
	task automatic send_byte(input uart_pkg::uart_byte_t data);
		logic full_before;
		i_tx_request = 1'b1;
		i_tx_data = data;
		full_before = DUT.tx_q.full;
		@(negedge i_clock);
		while (!o_tx_ready) begin
			if (full_before)
				full_waits++;
			full_before = DUT.tx_q.full;
			@(negedge i_clock);
		end
		assert (!full_before) else report_failure("o_tx_ready given while transmit FIFO full");
		tx_sent.push_back(data);
		bytes_accepted++;
		i_tx_request = 1'b0;
	endtask

	task automatic drive_frame(input uart_pkg::uart_byte_t data, input logic stop_bit);
		logic [9:0] frame;
		int b;
		frame = {stop_bit, data, 1'b0};
		for (b = 0; b < 10 * CLOCKS_PER_BIT; b++) begin
			gen_level = frame[b / CLOCKS_PER_BIT];
			@(negedge i_clock);
		end
		gen_level = 1'b1;
	endtask

	// Every bit must hold its level for exactly one bit period.
	task automatic decode_frame();
		uart_pkg::uart_byte_t expected;
		logic [9:0] frame;
		int b;
		int c;
		expected = '0;
		assert (tx_sent.size() != 0)
			else report_failure("Frame on o_tx_serial with no byte pending");
		if (tx_sent.size() != 0)
			expected = tx_sent.pop_front();
		if (!use_generator)
			rx_expect.push_back(expected);
		frame = {1'b1, expected, 1'b0};
		for (b = 0; b < 10; b++) begin
			for (c = 0; c < CLOCKS_PER_BIT; c++) begin
				if (b != 0 || c != 0)
					@(negedge i_clock);
				compare_value($sformatf("o_tx_serial bit %0d of byte %h", b, expected),
					32'(o_tx_serial), 32'(frame[b]));
			end
		end
		frames_seen++;
	endtask

	task automatic wait_drained();
		while (tx_sent.size() != 0 || rx_expect.size() != 0)
			@(negedge i_clock);
		repeat (2 * CLOCKS_PER_BIT) @(negedge i_clock);
	endtask

	initial begin : line_decoder
		forever begin
			@(negedge i_clock);
			if (!i_reset && o_tx_serial === 1'b0)
				decode_frame();
		end
	end

	// Loopback sampling, status pulse counts and host reads.
	initial begin : port_monitor
		i_rx_read = 1'b0;
		tx_loop = 1'b1;
		forever begin
			@(negedge i_clock);
			tx_loop = o_tx_serial;
			if (!i_reset && o_rx_frame_error)
				frame_errors++;
			if (!i_reset && o_rx_overrun)
				overruns++;
			if (!i_reset && read_enable && o_rx_valid) begin
				assert (rx_expect.size() != 0)
					else report_failure("Receiver delivered a byte that was never sent");
				if (rx_expect.size() != 0)
					compare_value("o_rx_data", 32'(o_rx_data), 32'(rx_expect.pop_front()));
				bytes_read++;
				i_rx_read = 1'b1;
			end else begin
				i_rx_read = 1'b0;
			end
		end
	end

	initial begin : watchdog
		while (cycles < CYCLE_LIMIT) begin
			@(posedge i_clock);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : main
		logic [31:0] r;
		int i;
		int base_frames;
		int base_reads;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_tx_request = 1'b0;
		i_tx_data = '0;
		use_generator = 1'b0;
		gen_level = 1'b1;
		read_enable = 1'b1;
		lfsr_state = 32'hb1013a5b;

		repeat (8) begin
			@(negedge i_clock);
			expect_idle();
		end
		i_reset = 1'b0;
		@(negedge i_clock);
		expect_idle();

		// Loopback with random gaps.
		for (i = 0; i < LOOP_BYTES; i++) begin
			random_bits(8, r);
			send_byte(r[7:0]);
			random_bits(4, r);
			repeat (r[3:0]) @(negedge i_clock);
		end
		wait_drained();

		// Burst that overfills the transmit FIFO.
		base_frames = frames_seen;
		full_waits = 0;
		for (i = 0; i < BURST_BYTES; i++) begin
			random_bits(8, r);
			send_byte(r[7:0]);
		end
		wait_drained();
		compare_value("frames on o_tx_serial", 32'(frames_seen - base_frames), BURST_BYTES);
		assert (full_waits > 0) else report_failure("Transmit FIFO never held off a request");
		compare_value("o_rx_frame_error pulses", 32'(frame_errors), 32'd0);
		compare_value("o_rx_overrun pulses", 32'(overruns), 32'd0);

		// Low stop bit with reads held off, then a good frame.
		use_generator = 1'b1;
		read_enable = 1'b0;
		random_bits(8, r);
		drive_frame(r[7:0], 1'b0);
		repeat (3 * CLOCKS_PER_BIT) @(negedge i_clock);
		compare_value("o_rx_frame_error pulses", 32'(frame_errors), 32'd1);
		compare_value("o_rx_valid", 32'(o_rx_valid), 32'd0);
		read_enable = 1'b1;
		random_bits(8, r);
		rx_expect.push_back(r[7:0]);
		drive_frame(r[7:0], 1'b1);
		wait_drained();

		// Reads held off until the receive FIFO overflows.
		read_enable = 1'b0;
		base_reads = bytes_read;
		for (i = 0; i < OVERRUN_FRAMES; i++) begin
			random_bits(8, r);
			if (i < FIFO_DEPTH)
				rx_expect.push_back(r[7:0]);
			drive_frame(r[7:0], 1'b1);
			repeat (CLOCKS_PER_BIT) @(negedge i_clock);
		end
		compare_value("o_rx_overrun pulses", 32'(overruns), 32'd1);
		compare_value("o_rx_frame_error pulses", 32'(frame_errors), 32'd1);
		read_enable = 1'b1;
		wait_drained();
		compare_value("bytes read after overrun", 32'(bytes_read - base_reads), FIFO_DEPTH);
		compare_value("frames against accepted bytes", 32'(frames_seen), 32'(bytes_accepted));

		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
source/uart_pkg.sv
source/fifo_if.sv
source/sync_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
dv/uart_chk.sv
dv/uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compiles the UART testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 --top-module uart_tb \
	-Mdir "$OBJ" -o uart_sim -f build.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/uart_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
	echo "No result line in $LOG"
	exit 1
fi
exit 0
